// File: design/cpuControl.sv
module cpuControl (
    input  logic                           PClk,
    input  logic                           rstN,
    input  ctrlPkg::instrWord_t            instr,
    input  logic                           compare,
    input  logic                           ready,
    input  logic [1:0]                     addrLow,
    input  logic [ctrlPkg::hwIntWidth-1:0] hwInt,
    input  logic [ctrlPkg::hwIntWidth-1:0] srIm,
    input  logic                           srExl,
    input  logic                           srIe,
    output logic                           pcWrite,
    output logic                           irWrite,
    output logic                           regWrite,
    output logic [1:0]                     regDst,
    output logic [1:0]                     rfSource,
    output logic                           aluSrcA,
    output logic [1:0]                     aluSrcB,
    output logic [1:0]                     aluOutSrc,
    output logic                           shtNumSrc,
    output ctrlPkg::aluOp_t                aluOp,
    output ctrlPkg::shtOp_t                shtOp,
    output logic [1:0]                     extFunct,
    output logic [2:0]                     pcSource,
    output logic                           req,
    output logic                           rw,
    output logic                           iorD,
    output logic [3:0]                     be,
    output logic [2:0]                     dExtFunct,
    output logic                           excEnter,
    output logic [4:0]                     excCode,
    output logic                           eret
);
    import ctrlPkg::*;

    instrClass_t instrClass;
    aluOp_t      decAluOp;
    shtOp_t      decShtOp;
    logic        shtFromReg;
    logic [1:0]  decExtFunct;
    accessSize_t accessSize;
    logic        loadUnsigned;
    logic        isLink;
    ctrlState_t  state;
    logic        intPending;

    instrDecoder i_instrDecoder (
        .instr, .instrClass, .aluOp(decAluOp), .shtOp(decShtOp), .shtFromReg,
        .extFunct(decExtFunct), .accessSize, .loadUnsigned, .isLink
    );

    stateSequencer i_stateSequencer (
        .PClk, .rstN, .instrClass, .accessSize, .ready, .intPending, .state
    );

    datapathCtrl i_datapathCtrl (
        .state, .instrClass, .aluOp(decAluOp), .shtOp(decShtOp), .shtFromReg,
        .extFunct(decExtFunct), .isLink, .compare, .ready,
        .pcWrite, .irWrite, .regWrite, .regDst, .rfSource, .aluSrcB, .aluOutSrc,
        .aluSrcA, .shtNumSrc, .aluOpOut(aluOp), .shtOpOut(shtOp),
        .extFunctOut(extFunct), .pcSource
    );

    memAccessCtrl i_memAccessCtrl (
        .state, .accessSize, .loadUnsigned, .addrLow,
        .req, .rw, .iorD, .be, .dExtFunct
    );

    exceptionCtrl i_exceptionCtrl (
        .state, .hwInt, .srIm, .srExl, .srIe,
        .intPending, .excEnter, .excCode, .eret
    );

endmodule

// File: design/ctrlPkg.sv
package ctrlPkg;

    localparam int hwIntWidth = 5;

    localparam logic [5:0] opR      = 6'b000000;
    localparam logic [5:0] opRegImm = 6'b000001;  // bgez/bltz picked by rt.
    localparam logic [5:0] opJ      = 6'b000010;
    localparam logic [5:0] opJal    = 6'b000011;
    localparam logic [5:0] opBeq    = 6'b000100;
    localparam logic [5:0] opBne    = 6'b000101;
    localparam logic [5:0] opBlez   = 6'b000110;
    localparam logic [5:0] opBgtz   = 6'b000111;
    localparam logic [5:0] opAddi   = 6'b001000;
    localparam logic [5:0] opAddiu  = 6'b001001;
    localparam logic [5:0] opSlti   = 6'b001010;
    localparam logic [5:0] opSltiu  = 6'b001011;
    localparam logic [5:0] opAndi   = 6'b001100;
    localparam logic [5:0] opOri    = 6'b001101;
    localparam logic [5:0] opXori   = 6'b001110;
    localparam logic [5:0] opLui    = 6'b001111;
    localparam logic [5:0] opCop0   = 6'b010000;
    localparam logic [5:0] opLb     = 6'b100000;
    localparam logic [5:0] opLh     = 6'b100001;
    localparam logic [5:0] opLw     = 6'b100011;
    localparam logic [5:0] opLbu    = 6'b100100;
    localparam logic [5:0] opLhu    = 6'b100101;
    localparam logic [5:0] opSb     = 6'b101000;
    localparam logic [5:0] opSh     = 6'b101001;
    localparam logic [5:0] opSw     = 6'b101011;

    localparam logic [5:0] fnSll     = 6'b000000;
    localparam logic [5:0] fnSrl     = 6'b000010;
    localparam logic [5:0] fnSra     = 6'b000011;
    localparam logic [5:0] fnSllv    = 6'b000100;
    localparam logic [5:0] fnSrlv    = 6'b000110;
    localparam logic [5:0] fnSrav    = 6'b000111;
    localparam logic [5:0] fnJr      = 6'b001000;
    localparam logic [5:0] fnJalr    = 6'b001001;
    localparam logic [5:0] fnSyscall = 6'b001100;
    localparam logic [5:0] fnBreak   = 6'b001101;
    localparam logic [5:0] fnEret    = 6'b011000;  // only under opCop0.
    localparam logic [5:0] fnAdd     = 6'b100000;
    localparam logic [5:0] fnAddu    = 6'b100001;
    localparam logic [5:0] fnSub     = 6'b100010;
    localparam logic [5:0] fnSubu    = 6'b100011;
    localparam logic [5:0] fnAnd     = 6'b100100;
    localparam logic [5:0] fnOr      = 6'b100101;
    localparam logic [5:0] fnXor     = 6'b100110;
    localparam logic [5:0] fnNor     = 6'b100111;
    localparam logic [5:0] fnSlt     = 6'b101010;
    localparam logic [5:0] fnSltu    = 6'b101011;

    localparam logic [1:0] regDstRt     = 2'd0;
    localparam logic [1:0] regDstRd     = 2'd1;
    localparam logic [1:0] regDstLink31 = 2'd2;

    localparam logic [1:0] rfSourceAluOut = 2'd0;
    localparam logic [1:0] rfSourceMdr    = 2'd1;
    localparam logic [1:0] rfSourcePc     = 2'd2;

    localparam logic aluSrcAPc  = 1'b0;
    localparam logic aluSrcAReg = 1'b1;

    localparam logic [1:0] aluSrcBReg  = 2'd0;
    localparam logic [1:0] aluSrcBFour = 2'd1;
    localparam logic [1:0] aluSrcBImm  = 2'd2;
    localparam logic [1:0] aluSrcBSimm = 2'd3;  // imm shifted left by two.

    localparam logic [1:0] aluOutSrcAlu = 2'd0;
    localparam logic [1:0] aluOutSrcSht = 2'd1;
    localparam logic [1:0] aluOutSrcImm = 2'd2;

    localparam logic [2:0] pcSourceAlu     = 3'd0;
    localparam logic [2:0] pcSourceAluOut  = 3'd1;
    localparam logic [2:0] pcSourceJTarget = 3'd2;
    localparam logic [2:0] pcSourceReg     = 3'd3;
    localparam logic [2:0] pcSourceVector  = 3'd4;
    localparam logic [2:0] pcSourceEpc     = 3'd5;

    localparam logic [1:0] extFunctSign = 2'd0;
    localparam logic [1:0] extFunctLui  = 2'd1;

    localparam logic [2:0] dExtFunctW  = 3'd0;
    localparam logic [2:0] dExtFunctB  = 3'd1;
    localparam logic [2:0] dExtFunctBu = 3'd2;
    localparam logic [2:0] dExtFunctH  = 3'd3;
    localparam logic [2:0] dExtFunctHu = 3'd4;

    localparam logic rwRead  = 1'b0;
    localparam logic rwWrite = 1'b1;

    localparam logic iorDPc     = 1'b0;
    localparam logic iorDAluOut = 1'b1;

    localparam logic [4:0] excCodeInt     = 5'd0;
    localparam logic [4:0] excCodeSyscall = 5'd8;
    localparam logic [4:0] excCodeBreak   = 5'd9;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields_t;

    typedef union packed {
        rFields_t rFields;
        iFields_t iFields;
    } instrWord_t;

    typedef enum logic [3:0] {
        stFetch, stDecode, stMemAdr, stMemRead, stMemWb, stMemWrite,
        stExecute, stAluWb, stBranch, stIExecute, stIWb, stJump,
        stInterrupt, stScException, stBpException, stEret
    } ctrlState_t;

    typedef enum logic [3:0] {
        clsAlu, clsShift, clsImm, clsLoad, clsStore, clsBranch,
        clsJump, clsSyscall, clsBreak, clsEret, clsNone
    } instrClass_t;

    typedef enum logic [4:0] {
        aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr, aluNor, aluXor,
        aluSlt, aluSltu, aluSeq, aluSne, aluGez, aluLtz, aluGtz, aluLez
    } aluOp_t;

    typedef enum logic [1:0] {shtSll, shtSrl, shtSra} shtOp_t;

    typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} accessSize_t;

endpackage

// File: design/datapathCtrl.sv
module datapathCtrl (
    input  ctrlPkg::ctrlState_t  state,
    input  ctrlPkg::instrClass_t instrClass,
    input  ctrlPkg::aluOp_t      aluOp,
    input  ctrlPkg::shtOp_t      shtOp,
    input  logic                 shtFromReg,
    input  logic [1:0]           extFunct,
    input  logic                 isLink,
    input  logic                 compare,
    input  logic                 ready,
    output logic                 pcWrite,
    output logic                 irWrite,
    output logic                 regWrite,
    output logic [1:0]           regDst,
    output logic [1:0]           rfSource,
    output logic [1:0]           aluSrcB,
    output logic [1:0]           aluOutSrc,
    output logic                 aluSrcA,
    output logic                 shtNumSrc,
    output ctrlPkg::aluOp_t      aluOpOut,
    output ctrlPkg::shtOp_t      shtOpOut,
    output logic [1:0]           extFunctOut,
    output logic [2:0]           pcSource
);
    import ctrlPkg::*;

    always_comb begin
        pcWrite     = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        regDst      = regDstRd;
        rfSource    = rfSourceAluOut;
        aluSrcA     = aluSrcAReg;
        aluSrcB     = aluSrcBReg;
        aluOutSrc   = aluOutSrcAlu;
        shtNumSrc   = shtFromReg;
        aluOpOut    = aluOp;
        shtOpOut    = shtOp;
        extFunctOut = extFunct;
        pcSource    = pcSourceAluOut;
        case (state)
            stFetch: begin
                pcWrite     = ready;
                irWrite     = ready;
                aluSrcA     = aluSrcAPc;
                aluSrcB     = aluSrcBFour;  // pc + 4.
                aluOpOut    = aluAddu;
                extFunctOut = extFunctSign;
                pcSource    = pcSourceAlu;
            end
            stDecode: begin
                aluSrcA     = aluSrcAPc;
                aluSrcB     = aluSrcBSimm;  // branch target into aluOut.
                aluOpOut    = aluAdd;
                extFunctOut = extFunctSign;
            end
            stMemAdr: aluSrcB = aluSrcBImm;
            stMemWb: begin
                regWrite = 1'b1;
                regDst   = regDstRt;
                rfSource = rfSourceMdr;
            end
            stExecute: aluOutSrc = (instrClass == clsShift) ? aluOutSrcSht : aluOutSrcAlu;
            stAluWb:   regWrite = 1'b1;
            stBranch:  pcWrite = compare;
            stIExecute: begin
                aluSrcB   = aluSrcBImm;
                aluOutSrc = (extFunct == extFunctLui) ? aluOutSrcImm : aluOutSrcAlu;
            end
            stIWb: begin
                regWrite = 1'b1;
                regDst   = regDstRt;
            end
            stJump: begin
                pcWrite  = 1'b1;
                pcSource = shtFromReg ? pcSourceReg : pcSourceJTarget;
                regWrite = isLink;
                regDst   = regDstLink31;
                rfSource = rfSourcePc;  // return address.
            end
            stInterrupt, stScException, stBpException: begin
                pcWrite  = 1'b1;
                pcSource = pcSourceVector;
            end
            stEret: begin
                pcWrite  = 1'b1;
                pcSource = pcSourceEpc;
            end
            default: pcWrite = 1'b0;
        endcase
    end

endmodule

// File: design/exceptionCtrl.sv
module exceptionCtrl (
    input  ctrlPkg::ctrlState_t           state,
    input  logic [ctrlPkg::hwIntWidth-1:0] hwInt,
    input  logic [ctrlPkg::hwIntWidth-1:0] srIm,
    input  logic                          srExl,
    input  logic                          srIe,
    output logic                          intPending,
    output logic                          excEnter,
    output logic [4:0]                    excCode,
    output logic                          eret
);
    import ctrlPkg::*;

    assign intPending = srIe && !srExl && |(hwInt & srIm);

    // excEnter also strobes the epc write.
    always_comb begin
        excEnter = 1'b0;
        excCode  = excCodeInt;
        eret     = 1'b0;
        case (state)
            stInterrupt: excEnter = 1'b1;
            stScException: begin
                excEnter = 1'b1;
                excCode  = excCodeSyscall;
            end
            stBpException: begin
                excEnter = 1'b1;
                excCode  = excCodeBreak;
            end
            stEret:  eret = 1'b1;
            default: eret = 1'b0;
        endcase
    end

endmodule

// File: design/instrDecoder.sv
module instrDecoder (
    input  ctrlPkg::instrWord_t  instr,
    output ctrlPkg::instrClass_t instrClass,
    output ctrlPkg::aluOp_t      aluOp,
    output ctrlPkg::shtOp_t      shtOp,
    output logic                 shtFromReg,
    output logic [1:0]           extFunct,
    output ctrlPkg::accessSize_t accessSize,
    output logic                 loadUnsigned,
    output logic                 isLink
);
    import ctrlPkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] rt;

    assign op    = instr.iFields.op;
    assign rt    = instr.iFields.rt;
    assign funct = instr.rFields.funct;

    // rs feeds the shift amount or the jump target.
    assign shtFromReg = (op == opR) && (funct inside {fnSllv, fnSrlv, fnSrav, fnJr, fnJalr});
    assign isLink     = (op == opJal) || ((op == opR) && (funct == fnJalr));
    assign extFunct   = (op == opLui) ? extFunctLui : extFunctSign;
    assign loadUnsigned = op inside {opLbu, opLhu};

    always_comb begin
        instrClass = clsNone;
        case (op)
            opR: begin
                case (funct)
                    fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
                    fnNor, fnXor, fnSlt, fnSltu:          instrClass = clsAlu;
                    fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: instrClass = clsShift;
                    fnJr, fnJalr:                         instrClass = clsJump;
                    fnSyscall:                            instrClass = clsSyscall;
                    fnBreak:                              instrClass = clsBreak;
                    default:                              instrClass = clsNone;
                endcase
            end
            opRegImm: instrClass = (rt[4:1] == 4'd0) ? clsBranch : clsNone;
            opBeq, opBne, opBgtz, opBlez: instrClass = clsBranch;
            opAddi, opAddiu, opAndi, opOri, opXori, opLui, opSlti, opSltiu: instrClass = clsImm;
            opLw, opLb, opLbu, opLh, opLhu: instrClass = clsLoad;
            opSw, opSb, opSh:               instrClass = clsStore;
            opJ, opJal:                     instrClass = clsJump;
            opCop0: instrClass = (funct == fnEret) ? clsEret : clsNone;
            default: instrClass = clsNone;
        endcase
    end

    always_comb begin
        aluOp = aluAdd;  // address add for loads and stores.
        case (op)
            opR: begin
                case (funct)
                    fnAddu:  aluOp = aluAddu;
                    fnSub:   aluOp = aluSub;
                    fnSubu:  aluOp = aluSubu;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnNor:   aluOp = aluNor;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    default: aluOp = aluAdd;
                endcase
            end
            opRegImm: aluOp = rt[0] ? aluGez : aluLtz;
            opBeq:    aluOp = aluSeq;
            opBne:    aluOp = aluSne;
            opBgtz:   aluOp = aluGtz;
            opBlez:   aluOp = aluLez;
            opAddiu:  aluOp = aluAddu;
            opAndi:   aluOp = aluAnd;
            opOri:    aluOp = aluOr;
            opXori:   aluOp = aluXor;
            opSlti:   aluOp = aluSlt;
            opSltiu:  aluOp = aluSltu;
            default:  aluOp = aluAdd;
        endcase
    end

    always_comb begin
        case (funct[1:0])
            2'b10:   shtOp = shtSrl;
            2'b11:   shtOp = shtSra;
            default: shtOp = shtSll;
        endcase
        case (op)
            opLb, opLbu, opSb: accessSize = sizeByte;
            opLh, opLhu, opSh: accessSize = sizeHalf;
            default:           accessSize = sizeWord;
        endcase
    end

endmodule

// File: design/memAccessCtrl.sv
module memAccessCtrl (
    input  ctrlPkg::ctrlState_t  state,
    input  ctrlPkg::accessSize_t accessSize,
    input  logic                 loadUnsigned,
    input  logic [1:0]           addrLow,
    output logic                 req,
    output logic                 rw,
    output logic                 iorD,
    output logic [3:0]           be,
    output logic [2:0]           dExtFunct
);
    import ctrlPkg::*;

    logic [3:0] laneBe;

    always_comb begin
        case (accessSize)
            sizeByte: laneBe = 4'b0001 << addrLow;
            sizeHalf: laneBe = addrLow[0] ? 4'b1111 : (addrLow[1] ? 4'b1100 : 4'b0011);
            default:  laneBe = 4'b1111;
        endcase
        case (accessSize)
            sizeByte: dExtFunct = loadUnsigned ? dExtFunctBu : dExtFunctB;
            sizeHalf: dExtFunct = loadUnsigned ? dExtFunctHu : dExtFunctH;
            default:  dExtFunct = dExtFunctW;
        endcase
    end

    assign req  = state inside {stFetch, stMemRead, stMemWrite};  // held until ready.
    assign rw   = (state == stMemWrite) ? rwWrite : rwRead;
    assign iorD = (state == stFetch) ? iorDPc : iorDAluOut;
    assign be   = (state == stFetch) ? 4'b1111 : laneBe;

endmodule

// File: design/stateSequencer.sv
module stateSequencer (
    input  logic                 PClk,
    input  logic                 rstN,
    input  ctrlPkg::instrClass_t instrClass,
    input  ctrlPkg::accessSize_t accessSize,
    input  logic                 ready,
    input  logic                 intPending,
    output ctrlPkg::ctrlState_t  state
);
    import ctrlPkg::*;

    ctrlState_t nextState;
    ctrlState_t doneState;

    assign doneState = intPending ? stInterrupt : stFetch;  // end of instruction.

    always_ff @(posedge PClk or negedge rstN) begin
        if (!rstN) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = stFetch;
        case (state)
            stFetch: nextState = ready ? stDecode : stFetch;
            stDecode: begin
                case (instrClass)
                    clsAlu, clsShift:  nextState = stExecute;
                    clsImm:            nextState = stIExecute;
                    clsLoad, clsStore: nextState = stMemAdr;
                    clsBranch:         nextState = stBranch;
                    clsJump:           nextState = stJump;
                    clsSyscall:        nextState = stScException;
                    clsBreak:          nextState = stBpException;
                    clsEret:           nextState = stEret;
                    default:           nextState = doneState;  // unknown opcode.
                endcase
            end
            stMemAdr:   nextState = (instrClass == clsLoad) ? stMemRead : stMemWrite;
            stMemRead:  nextState = ready ? stMemWb : stMemRead;
            stMemWrite: nextState = ready ? doneState : stMemWrite;
            stExecute:  nextState = stAluWb;
            stIExecute: nextState = stIWb;
            stMemWb, stAluWb, stBranch, stIWb, stJump: nextState = doneState;
            default:    nextState = stFetch;  // exception entry and eret.
        endcase
    end

endmodule

// File: sim/tbCpuControl.sv
module tbCpuControl;
    timeunit 1ns;
    timeprecision 100ps;
    import ctrlPkg::*;

    logic PClk, rstN, compare, ready, srExl, srIe;
    instrWord_t instr;
    logic [1:0] addrLow;
    logic [hwIntWidth-1:0] hwInt, srIm;
    logic pcWrite, irWrite, regWrite, aluSrcA, shtNumSrc, req, rw, iorD, excEnter, eret;
    logic [1:0] regDst, rfSource, aluSrcB, aluOutSrc, extFunct;
    logic [2:0] pcSource, dExtFunct;
    logic [3:0] be;
    logic [4:0] excCode;
    aluOp_t aluOp;
    shtOp_t shtOp;
    int checkCount = 0;
    int errorCount = 0;

    cpuControl i_cpuControl (.*);

    always #50 PClk = ~PClk;

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string msg);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h",
                     $time, msg, got, expected);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        $display("Timeout at %0d ns: %s", $time, what);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic toDrive();
        @(posedge PClk);
        #5;
    endtask

    task automatic toMid();
        @(negedge PClk);
    endtask

    // lane rule for the byte enables.
    function automatic logic [3:0] expectBe(input int bytes, input logic [1:0] a);
        if (bytes == 1) return 4'b0001 << a;
        if (bytes == 2 && a == 2'd0) return 4'b0011;
        if (bytes == 2 && a == 2'd2) return 4'b1100;
        return 4'b1111;
    endfunction

    // ends in the middle of cycle 0, the fetch cycle with ready high.
    task automatic fetchInstr(input logic [31:0] word, input int delay);
        int n;
        n = 0;
        toDrive();
        while (!(req && iorD == iorDPc)) begin
            if (n == 20) reportTimeout("the FSM never came back to fetch");
            toDrive();
            n++;
        end
        instr = word;
        ready = 1'b0;
        repeat (delay) begin
            toMid();
            checkValue(pcWrite, 0, "pcWrite during fetch stall");
            checkValue(irWrite, 0, "irWrite during fetch stall");
            checkValue(req, 1, "req during fetch stall");
            toDrive();
        end
        ready = 1'b1;
        toMid();
        checkValue(pcWrite, 1, "pcWrite in fetch");
        checkValue(irWrite, 1, "irWrite in fetch");
        checkValue(aluSrcA, aluSrcAPc, "aluSrcA in fetch");
    endtask

    task automatic aluCase(input logic [5:0] fn, input bit isShift, input aluOp_t expOp,
                           input shtOp_t expSht, input logic expNum);
        fetchInstr({opR, 5'd4, 5'd5, 5'd6, 5'd2, fn}, 0);
        toMid();
        toMid();
        checkValue(aluSrcA, aluSrcAReg, "R-type aluSrcA");
        if (isShift) begin
            checkValue(aluOutSrc, aluOutSrcSht, "shift aluOutSrc");
            checkValue(shtOp, expSht, "shtOp");
            checkValue(shtNumSrc, expNum, "shtNumSrc");
        end else begin
            checkValue(aluOutSrc, aluOutSrcAlu, "R-type aluOutSrc");
            checkValue(aluOp, expOp, "R-type aluOp");
        end
        toMid();
        checkValue(regWrite, 1, "R-type regWrite");
        checkValue(regDst, regDstRd, "R-type regDst");
        checkValue(rfSource, rfSourceAluOut, "R-type rfSource");
    endtask

    task automatic immCase(input logic [5:0] op, input aluOp_t expOp, input logic [1:0] expExt);
        fetchInstr({op, 5'd4, 5'd7, 16'h8123}, 0);
        toMid();
        toMid();
        checkValue(aluSrcB, aluSrcBImm, "I-type aluSrcB");
        checkValue(extFunct, expExt, "I-type extFunct");
        if (expExt == extFunctLui) begin
            checkValue(aluOutSrc, aluOutSrcImm, "LUI aluOutSrc");
        end else begin
            checkValue(aluOutSrc, aluOutSrcAlu, "I-type aluOutSrc");
            checkValue(aluOp, expOp, "I-type aluOp");
        end
        toMid();
        checkValue(regWrite, 1, "I-type regWrite");
        checkValue(regDst, regDstRt, "I-type regDst");
    endtask

    task automatic memCase(input logic [5:0] op, input int bytes, input bit isLoad,
                           input logic [2:0] expExt);
        logic [1:0] a;
        int delay;
        a = 2'($urandom % 4);
        delay = $urandom % 4;
        fetchInstr({op, 5'd8, 5'd9, 16'h0010}, 0);
        toDrive();
        addrLow = a;  // cycle 1.
        toDrive();
        ready = 1'b0;
        toMid();
        checkValue(req, 0, "req in memAdr");
        toDrive();
        for (int i = 0; i <= delay; i++) begin
            ready = (i == delay);
            toMid();
            checkValue(req, 1, "req during access");
            checkValue(iorD, iorDAluOut, "iorD during access");
            checkValue(rw, isLoad ? rwRead : rwWrite, "rw during access");
            checkValue(be, expectBe(bytes, a), "byte enables");
            if (isLoad) checkValue(dExtFunct, expExt, "load extend mode");
            checkValue(regWrite, 0, "regWrite during access");
            toDrive();
        end
        ready = 1'b0;
        toMid();
        if (isLoad) begin
            checkValue(regWrite, 1, "load regWrite");
            checkValue(rfSource, rfSourceMdr, "load rfSource");
            checkValue(regDst, regDstRt, "load regDst");
        end else begin
            checkValue(req && iorD == iorDPc, 1, "fetch after store");
        end
    endtask

    task automatic branchCase(input logic [5:0] op, input logic [4:0] rt, input aluOp_t expOp);
        logic cmp;
        cmp = 1'($urandom);
        fetchInstr({op, 5'd3, rt, 16'h0004}, 0);
        toDrive();
        compare = cmp;
        toMid();
        toMid();
        checkValue(pcWrite, cmp, "branch pcWrite");
        checkValue(aluOp, expOp, "branch aluOp");
    endtask

    task automatic jumpCase(input logic [31:0] word, input logic [2:0] expSrc, input bit link);
        fetchInstr(word, 0);
        toMid();
        toMid();
        checkValue(pcWrite, 1, "jump pcWrite");
        checkValue(pcSource, expSrc, "jump pcSource");
        checkValue(regWrite, link, "jump regWrite");
        if (link) checkValue(regDst, regDstLink31, "link regDst");
    endtask

    task automatic excCase(input logic [31:0] word, input logic [4:0] code, input bit isEret);
        fetchInstr(word, 0);
        toMid();
        toMid();
        checkValue(pcWrite, 1, "exception pcWrite");
        checkValue(eret, isEret, "eret strobe");
        checkValue(excEnter, !isEret, "excEnter");
        checkValue(pcSource, isEret ? pcSourceEpc : pcSourceVector, "exception pcSource");
        if (!isEret) checkValue(excCode, code, "excCode");
    endtask

    task automatic intCase(input logic exl, input logic ie);
        fetchInstr({opR, 5'd1, 5'd2, 5'd3, 5'd0, fnAdd}, 0);
        toDrive();
        hwInt = 5'b00100;  // cycle 1.
        srIm  = 5'b00110;
        srExl = exl;
        srIe  = ie;
        repeat (4) toMid();
        if (ie && !exl) begin
            checkValue(excEnter, 1, "excEnter on interrupt");
            checkValue(excCode, excCodeInt, "interrupt excCode");
            checkValue(pcSource, pcSourceVector, "interrupt pcSource");
            checkValue(pcWrite, 1, "interrupt pcWrite");
        end else begin
            checkValue(req && iorD == iorDPc, 1, "fetch with interrupt disabled");
            checkValue(excEnter, 0, "no excEnter with interrupt disabled");
        end
        toDrive();
        hwInt = '0;
    endtask

    initial begin
        void'($urandom(32'haee07168));
        PClk = 1'b0;
        rstN = 1'b0;
        instr = '0;
        {compare, ready, srExl, srIe, addrLow, hwInt, srIm} = '0;
        repeat (16) @(posedge PClk);
        #5 rstN = 1'b1;
        toMid();
        checkValue(req, 1, "req after reset");
        checkValue(regWrite | excEnter | eret, 0, "strobes after reset");
        checkValue(pcWrite, 0, "pcWrite after reset, ready low");
        fetchInstr({opR, 5'd4, 5'd5, 5'd6, 5'd0, fnAdd}, 3);  // back-pressure.
        aluCase(fnAdd, 0, aluAdd, shtSll, 0);
        aluCase(fnSubu, 0, aluSubu, shtSll, 0);
        aluCase(fnNor, 0, aluNor, shtSll, 0);
        aluCase(fnSlt, 0, aluSlt, shtSll, 0);
        aluCase(fnSll, 1, aluAdd, shtSll, 0);
        aluCase(fnSrav, 1, aluAdd, shtSra, 1);
        immCase(opAddi, aluAdd, extFunctSign);
        immCase(opOri, aluOr, extFunctSign);
        immCase(opSltiu, aluSltu, extFunctSign);
        immCase(opLui, aluAdd, extFunctLui);
        memCase(opLb, 1, 1, dExtFunctB);
        memCase(opLbu, 1, 1, dExtFunctBu);
        memCase(opLh, 2, 1, dExtFunctH);
        memCase(opLhu, 2, 1, dExtFunctHu);
        memCase(opLw, 4, 1, dExtFunctW);
        memCase(opSb, 1, 0, dExtFunctW);
        memCase(opSh, 2, 0, dExtFunctW);
        memCase(opSw, 4, 0, dExtFunctW);
        branchCase(opBeq, 5'd2, aluSeq);
        branchCase(opBne, 5'd2, aluSne);
        branchCase(opBgtz, 5'd0, aluGtz);
        branchCase(opBlez, 5'd0, aluLez);
        branchCase(opRegImm, 5'd1, aluGez);
        branchCase(opRegImm, 5'd0, aluLtz);
        jumpCase({opJ, 26'h0000100}, pcSourceJTarget, 0);
        jumpCase({opJal, 26'h0000200}, pcSourceJTarget, 1);
        jumpCase({opR, 5'd31, 15'd0, fnJr}, pcSourceReg, 0);
        jumpCase({opR, 5'd3, 5'd0, 5'd31, 5'd0, fnJalr}, pcSourceReg, 1);
        excCase({opR, 20'd0, fnSyscall}, excCodeSyscall, 0);
        excCase({opR, 20'd0, fnBreak}, excCodeBreak, 0);
        excCase({opCop0, 5'b10000, 15'd0, fnEret}, excCodeInt, 1);
        intCase(0, 1);
        intCase(1, 1);
        intCase(0, 0);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/ctrlPkg.sv
design/instrDecoder.sv
design/stateSequencer.sv
design/datapathCtrl.sv
design/memAccessCtrl.sv
design/exceptionCtrl.sv
design/cpuControl.sv
sim/tbCpuControl.sv
